//--- src/pmp_params.svh
// PMP checker sizing

`ifndef PMP_PARAMS_SVH
`define PMP_PARAMS_SVH

`default_nettype none

////////////////////////////////////////
// rule table size
////////////////////////////////////////

// number of rules held in the register block
`define PMP_ENTRIES 8

////////////////////////////////////////
// address widths
////////////////////////////////////////

// byte address width of an access
`define PMP_ADDR_W 32

// word address width, byte address bits [31:2]
`define PMP_WADDR_W 30

// largest trailing-ones count accepted for NAPOT
// 15 gives 2^(15+3) bytes, i.e. 256 KB
`define PMP_NAPOT_MAX_G 15

`default_nettype wire

`endif

//--- src/pmp_cfg_pkg.sv
// PMP rule configuration types

`default_nettype none

package pmp_cfg_pkg;

   ////////////////////////////////////////
   // address matching mode
   ////////////////////////////////////////

   typedef enum logic [1:0]
   {
      OFF   = 2'b00,
      TOR   = 2'b01,
      NA4   = 2'b10,
      NAPOT = 2'b11
   } pmp_mode_e;

   ////////////////////////////////////////
   // configuration byte
   ////////////////////////////////////////

   // same bit order as the pmpcfg byte of the privileged spec
   typedef struct packed
   {
      logic      lock;
      logic [1:0] wiri;
      pmp_mode_e mode;
      logic      x;
      logic      w;
      logic      r;
   } pmp_cfg_t;

endpackage

`default_nettype wire

//--- src/pmp_bus_pkg.sv
// PMP access side types

`default_nettype none

package pmp_bus_pkg;

   ////////////////////////////////////////
   // privilege level of the access
   ////////////////////////////////////////

   // encoding follows the mstatus.MPP field
   // 2'b10 is reserved
   typedef enum logic [1:0]
   {
      U = 2'b00,
      S = 2'b01,
      M = 2'b11
   } pmp_priv_e;

endpackage

`default_nettype wire

//--- src/pmp_cfg_regs.sv
// PMP rule register block

`include "pmp_params.svh"

`default_nettype none

module pmp_cfg_regs
(
   input  logic                                       clk_i,
   input  logic                                       arst_n_i,

   input  logic                                       cfg_we_i,
   input  logic [$clog2(`PMP_ENTRIES)-1:0]            cfg_idx_i,
   input  pmp_cfg_pkg::pmp_cfg_t                      cfg_data_i,
   input  logic [`PMP_ADDR_W-1:0]                     addr_data_i,

   output pmp_cfg_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0]   cfg_o,
   output logic [`PMP_ENTRIES-1:0][`PMP_ADDR_W-1:0]   addr_o
);

   pmp_cfg_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0]   cfg_q;
   logic [`PMP_ENTRIES-1:0][`PMP_ADDR_W-1:0]   addr_q;
   pmp_cfg_pkg::pmp_cfg_t                      wr_cfg;
   logic                                       wr_allow;

   // reserved bits are stored as zero
   always_comb
   begin
      wr_cfg      = cfg_data_i;
      wr_cfg.wiri = 2'b00;
   end

   // a set lock bit freezes the entry until reset
   assign wr_allow = cfg_we_i & ~cfg_q[cfg_idx_i].lock;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cfg_q  <= '0;
         addr_q <= '0;
      end
      else if (wr_allow)
      begin
         cfg_q[cfg_idx_i]  <= wr_cfg;
         addr_q[cfg_idx_i] <= addr_data_i;
      end
   end

   assign cfg_o  = cfg_q;
   assign addr_o = addr_q;

   ////////////////////////////////////////
   // lock checks
   ////////////////////////////////////////

   genvar i;
   for (i = 0; i < `PMP_ENTRIES; i++)
   begin : g_lock_chk
      // once locked, both halves of the entry hold their value
      a_locked_stable : assert property (
         @(posedge clk_i) disable iff (!arst_n_i)
         $past(cfg_q[i].lock) |-> (cfg_q[i] == $past(cfg_q[i]))
                                  && (addr_q[i] == $past(addr_q[i]))
      );
   end

endmodule

`default_nettype wire

//--- src/pmp_region_decode.sv
// PMP region decoder

`include "pmp_params.svh"

`default_nettype none

module pmp_region_decode
(
   input  pmp_cfg_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0]   cfg_i,
   input  logic [`PMP_ENTRIES-1:0][`PMP_ADDR_W-1:0]   addr_i,

   output logic [`PMP_ENTRIES-1:0]                    rule_en_o,
   output logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  base_o,
   output logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  limit_o,
   output logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  mask_o
);

   // count of consecutive ones from bit 0 upward
   function automatic int unsigned trailing_ones(input logic [`PMP_WADDR_W-1:0] word);
      int unsigned cnt;
      logic        run;
      cnt = 0;
      run = 1'b1;
      for (int b = 0; b < `PMP_WADDR_W; b++)
      begin
         run = run & word[b];
         if (run)
         begin
            cnt++;
         end
      end
      return cnt;
   endfunction

   genvar i;
   for (i = 0; i < `PMP_ENTRIES; i++)
   begin : g_rule
      logic [`PMP_WADDR_W-1:0] word;
      logic [`PMP_WADDR_W-1:0] prev_word;
      int unsigned             t_ones;

      // only bits [29:0] of the address register take part
      assign word = addr_i[i][`PMP_WADDR_W-1:0];

      // TOR bottom of entry 0 is address zero
      if (i == 0)
      begin : g_first
         assign prev_word = '0;
      end
      else
      begin : g_next
         assign prev_word = addr_i[i-1][`PMP_WADDR_W-1:0];
      end

      assign t_ones = trailing_ones(word);

      always_comb
      begin
         rule_en_o[i] = 1'b0;
         base_o[i]    = '0;
         limit_o[i]   = '0;
         mask_o[i]    = '1;

         case (cfg_i[i].mode)
            pmp_cfg_pkg::TOR:
            begin
               rule_en_o[i] = 1'b1;
               base_o[i]    = prev_word;
               limit_o[i]   = word;
            end

            pmp_cfg_pkg::NA4:
            begin
               rule_en_o[i] = 1'b1;
               base_o[i]    = word;
               limit_o[i]   = word;
            end

            pmp_cfg_pkg::NAPOT:
            begin
               // t ones plus the terminating zero are don't-care bits
               mask_o[i]  = {`PMP_WADDR_W{1'b1}} << (t_ones + 1);
               base_o[i]  = word & mask_o[i];
               limit_o[i] = word;
               // too large for the ceiling, or no terminating zero at all
               rule_en_o[i] = (t_ones <= `PMP_NAPOT_MAX_G) && (word != '1);
            end

            default:
            begin
               rule_en_o[i] = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/pmp_port_check.sv
// PMP check for one access port

`include "pmp_params.svh"

`default_nettype none

module pmp_port_check
#(
   parameter bit FETCH_SIDE = 1'b0
)
(
   input  logic                                       clk_i,
   input  logic                                       arst_n_i,

   input  pmp_bus_pkg::pmp_priv_e                     priv_i,

   input  pmp_cfg_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0]   cfg_i,
   input  logic [`PMP_ENTRIES-1:0]                    rule_en_i,
   input  logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  base_i,
   input  logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  limit_i,
   input  logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]  mask_i,

   // toward the core
   input  logic                                       req_i,
   input  logic [`PMP_ADDR_W-1:0]                     addr_i,
   input  logic                                       we_i,
   output logic                                       gnt_o,

   // toward memory
   output logic                                       req_o,
   input  logic                                       gnt_i,
   output logic [`PMP_ADDR_W-1:0]                     addr_o,
   output logic                                       err_o
);

   logic [`PMP_WADDR_W-1:0]  waddr;
   logic [`PMP_ENTRIES-1:0]  perm_ok;
   logic [`PMP_ENTRIES-1:0]  region_hit;
   logic [`PMP_ENTRIES-1:0]  rule_match;
   logic                     allowed;

   assign waddr = addr_i[`PMP_ADDR_W-1:2];

   ////////////////////////////////////////
   // per rule match
   ////////////////////////////////////////

   always_comb
   begin
      for (int j = 0; j < `PMP_ENTRIES; j++)
      begin
         // fetch needs X, data needs W on a write and R on a read
         if (FETCH_SIDE)
         begin
            perm_ok[j] = cfg_i[j].x;
         end
         else
         begin
            perm_ok[j] = we_i ? cfg_i[j].w : cfg_i[j].r;
         end

         case (cfg_i[j].mode)
            pmp_cfg_pkg::TOR:   region_hit[j] = (waddr >= base_i[j]) && (waddr < limit_i[j]);
            pmp_cfg_pkg::NA4:   region_hit[j] = (waddr == base_i[j]);
            pmp_cfg_pkg::NAPOT: region_hit[j] = ((waddr & mask_i[j]) == base_i[j]);
            default:            region_hit[j] = 1'b0;
         endcase

         rule_match[j] = rule_en_i[j] & perm_ok[j] & region_hit[j];
      end
   end

   ////////////////////////////////////////
   // request gating
   ////////////////////////////////////////

   // machine mode bypasses every rule
   assign allowed = (priv_i == pmp_bus_pkg::M) | (|rule_match);

   assign req_o  = req_i & allowed;
   assign gnt_o  = gnt_i & allowed;
   assign err_o  = req_i & ~allowed;
   assign addr_o = addr_i;

   // memory grants only what was requested
   a_gnt_with_req : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      gnt_o |-> req_o
   );

endmodule

`default_nettype wire

//--- src/pmp_top.sv
// PMP checker top level

`include "pmp_params.svh"

`default_nettype none

module pmp_top
(
   input  logic                                  clk_i,
   input  logic                                  arst_n_i,

   // rule write port
   input  logic                                  cfg_we_i,
   input  logic [$clog2(`PMP_ENTRIES)-1:0]       cfg_idx_i,
   input  pmp_cfg_pkg::pmp_cfg_t                 cfg_data_i,
   input  logic [`PMP_ADDR_W-1:0]                addr_data_i,

   input  pmp_bus_pkg::pmp_priv_e                priv_i,

   // data side, core
   input  logic                                  data_req_i,
   input  logic [`PMP_ADDR_W-1:0]                data_addr_i,
   input  logic                                  data_we_i,
   output logic                                  data_gnt_o,
   // data side, memory
   output logic                                  data_req_o,
   input  logic                                  data_gnt_i,
   output logic [`PMP_ADDR_W-1:0]                data_addr_o,
   output logic                                  data_err_o,

   // fetch side, core
   input  logic                                  instr_req_i,
   input  logic [`PMP_ADDR_W-1:0]                instr_addr_i,
   output logic                                  instr_gnt_o,
   // fetch side, prefetch buffer
   output logic                                  instr_req_o,
   input  logic                                  instr_gnt_i,
   output logic [`PMP_ADDR_W-1:0]                instr_addr_o,
   output logic                                  instr_err_o
);

   pmp_cfg_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0]    rule_cfg;
   logic [`PMP_ENTRIES-1:0][`PMP_ADDR_W-1:0]    rule_addr;
   logic [`PMP_ENTRIES-1:0]                     rule_en;
   logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]   rule_base;
   logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]   rule_limit;
   logic [`PMP_ENTRIES-1:0][`PMP_WADDR_W-1:0]   rule_mask;

   pmp_cfg_regs cfg_regs_i
   (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_idx_i   (cfg_idx_i),
      .cfg_data_i  (cfg_data_i),
      .addr_data_i (addr_data_i),
      .cfg_o       (rule_cfg),
      .addr_o      (rule_addr)
   );

   pmp_region_decode region_decode_i
   (
      .cfg_i     (rule_cfg),
      .addr_i    (rule_addr),
      .rule_en_o (rule_en),
      .base_o    (rule_base),
      .limit_o   (rule_limit),
      .mask_o    (rule_mask)
   );

   ////////////////////////////////////////
   // port checks
   ////////////////////////////////////////

   pmp_port_check #(.FETCH_SIDE(1'b0)) data_check_i
   (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .priv_i    (priv_i),
      .cfg_i     (rule_cfg),
      .rule_en_i (rule_en),
      .base_i    (rule_base),
      .limit_i   (rule_limit),
      .mask_i    (rule_mask),
      .req_i     (data_req_i),
      .addr_i    (data_addr_i),
      .we_i      (data_we_i),
      .gnt_o     (data_gnt_o),
      .req_o     (data_req_o),
      .gnt_i     (data_gnt_i),
      .addr_o    (data_addr_o),
      .err_o     (data_err_o)
   );

   // fetches never write
   pmp_port_check #(.FETCH_SIDE(1'b1)) instr_check_i
   (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .priv_i    (priv_i),
      .cfg_i     (rule_cfg),
      .rule_en_i (rule_en),
      .base_i    (rule_base),
      .limit_i   (rule_limit),
      .mask_i    (rule_mask),
      .req_i     (instr_req_i),
      .addr_i    (instr_addr_i),
      .we_i      (1'b0),
      .gnt_o     (instr_gnt_o),
      .req_o     (instr_req_o),
      .gnt_i     (instr_gnt_i),
      .addr_o    (instr_addr_o),
      .err_o     (instr_err_o)
   );

endmodule

`default_nettype wire

//--- tb/pmp_tb.sv
// PMP checker testbench

`include "pmp_params.svh"

`default_nettype none

module pmp_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int IDX_W       = $clog2(`PMP_ENTRIES);
   // the directed tests need well under this many cycles
   localparam int TEST_CYCLES = 400;
   localparam int CYCLE_LIMIT = 5 * TEST_CYCLES;

   logic                        clk_i;
   logic                        arst_n_i;
   logic                        cfg_we_i;
   logic [IDX_W-1:0]            cfg_idx_i;
   pmp_cfg_pkg::pmp_cfg_t       cfg_data_i;
   logic [`PMP_ADDR_W-1:0]      addr_data_i;
   pmp_bus_pkg::pmp_priv_e      priv_i;
   logic                        data_req_i;
   logic [`PMP_ADDR_W-1:0]      data_addr_i;
   logic                        data_we_i;
   logic                        data_gnt_o;
   logic                        data_req_o;
   logic                        data_gnt_i;
   logic [`PMP_ADDR_W-1:0]      data_addr_o;
   logic                        data_err_o;
   logic                        instr_req_i;
   logic [`PMP_ADDR_W-1:0]      instr_addr_i;
   logic                        instr_gnt_o;
   logic                        instr_req_o;
   logic                        instr_gnt_i;
   logic [`PMP_ADDR_W-1:0]      instr_addr_o;
   logic                        instr_err_o;

   integer seed = 32'hc290fdd5;
   int     cycle_cnt = 0;
   int     err_cnt = 0;
   int     test_errs = 0;
   int     test_cnt = 0;
   int     failed_tests = 0;

   pmp_top pmp_top_i
   (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_idx_i    (cfg_idx_i),
      .cfg_data_i   (cfg_data_i),
      .addr_data_i  (addr_data_i),
      .priv_i       (priv_i),
      .data_req_i   (data_req_i),
      .data_addr_i  (data_addr_i),
      .data_we_i    (data_we_i),
      .data_gnt_o   (data_gnt_o),
      .data_req_o   (data_req_o),
      .data_gnt_i   (data_gnt_i),
      .data_addr_o  (data_addr_o),
      .data_err_o   (data_err_o),
      .instr_req_i  (instr_req_i),
      .instr_addr_i (instr_addr_i),
      .instr_gnt_o  (instr_gnt_o),
      .instr_req_o  (instr_req_o),
      .instr_gnt_i  (instr_gnt_i),
      .instr_addr_o (instr_addr_o),
      .instr_err_o  (instr_err_o)
   );

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // inputs change 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #10;
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         err_cnt++;
         test_errs++;
      end
   endtask

   task automatic check_word(input string name, input logic [`PMP_ADDR_W-1:0] got,
                             input logic [`PMP_ADDR_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         err_cnt++;
         test_errs++;
      end
   endtask

   function automatic pmp_cfg_pkg::pmp_cfg_t make_cfg(input logic lock,
      input pmp_cfg_pkg::pmp_mode_e mode, input logic x, input logic w, input logic r);
      pmp_cfg_pkg::pmp_cfg_t c;
      c.lock = lock;
      c.wiri = 2'b00;
      c.mode = mode;
      c.x    = x;
      c.w    = w;
      c.r    = r;
      return c;
   endfunction

   task automatic write_rule(input logic [IDX_W-1:0] idx, input pmp_cfg_pkg::pmp_cfg_t cfg,
                             input logic [`PMP_ADDR_W-1:0] addr);
      cfg_we_i    = 1'b1;
      cfg_idx_i   = idx;
      cfg_data_i  = cfg;
      addr_data_i = addr;
      next_cycle();
      cfg_we_i    = 1'b0;
   endtask

   // locked entries simply keep their value
   task automatic clear_rules();
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         write_rule(IDX_W'(i), '0, '0);
      end
   endtask

   task automatic expect_data(input logic [`PMP_ADDR_W-1:0] addr, input logic we,
                              input logic gnt, input logic exp_ok);
      data_req_i  = 1'b1;
      data_addr_i = addr;
      data_we_i   = we;
      data_gnt_i  = gnt;
      #30;
      check_bit("data_req_o", data_req_o, exp_ok);
      check_bit("data_gnt_o", data_gnt_o, exp_ok & gnt);
      check_bit("data_err_o", data_err_o, ~exp_ok);
      check_word("data_addr_o", data_addr_o, addr);
      next_cycle();
   endtask

   task automatic expect_fetch(input logic [`PMP_ADDR_W-1:0] addr, input logic gnt,
                               input logic exp_ok);
      instr_req_i  = 1'b1;
      instr_addr_i = addr;
      instr_gnt_i  = gnt;
      #30;
      check_bit("instr_req_o", instr_req_o, exp_ok);
      check_bit("instr_gnt_o", instr_gnt_o, exp_ok & gnt);
      check_bit("instr_err_o", instr_err_o, ~exp_ok);
      check_word("instr_addr_o", instr_addr_o, addr);
      next_cycle();
   endtask

   task automatic end_test(input string name);
      data_req_i  = 1'b0;
      data_gnt_i  = 1'b0;
      data_we_i   = 1'b0;
      instr_req_i = 1'b0;
      instr_gnt_i = 1'b0;
      test_cnt++;
      if (test_errs == 0)
      begin
         $display("test %s passed", name);
      end
      else
      begin
         $display("test %s failed with %0d errors", name, test_errs);
         failed_tests++;
      end
      test_errs = 0;
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////

   task automatic test_reset_state();
      logic [31:0] rnd;
      rnd    = $random(seed);
      priv_i = pmp_bus_pkg::U;
      expect_data(32'h0000_0000, 1'b0, 1'b1, 1'b0);
      expect_data(rnd, 1'b1, 1'b1, 1'b0);
      expect_fetch(32'h0000_0100, 1'b1, 1'b0);
      expect_fetch(rnd, 1'b1, 1'b0);
      // machine mode ignores the empty rule table
      priv_i = pmp_bus_pkg::M;
      expect_data(rnd, 1'b0, 1'b1, 1'b1);
      expect_data(rnd, 1'b1, 1'b0, 1'b1);
      expect_fetch(rnd, 1'b1, 1'b1);
      expect_fetch(32'h0000_0100, 1'b0, 1'b1);
      end_test("reset_state");
   endtask

   task automatic test_na4();
      clear_rules();
      priv_i = pmp_bus_pkg::U;
      write_rule(0, make_cfg(1'b0, pmp_cfg_pkg::NA4, 1'b0, 1'b0, 1'b1), 32'h0000_048c);
      expect_data(32'h0000_1230, 1'b0, 1'b1, 1'b1);
      expect_data(32'h0000_1233, 1'b0, 1'b1, 1'b1);
      expect_data(32'h0000_1230, 1'b1, 1'b1, 1'b0);
      expect_data(32'h0000_1234, 1'b0, 1'b1, 1'b0);
      expect_data(32'h0000_122c, 1'b0, 1'b1, 1'b0);
      expect_fetch(32'h0000_1230, 1'b1, 1'b0);
      end_test("na4");
   endtask

   // region of 2^(t+1) words, placed away from both ends of the space
   task automatic napot_size(input int t, input logic exp_in);
      logic [29:0] span;
      logic [29:0] wbase;
      logic [31:0] rnd;
      rnd   = $random(seed);
      span  = (30'd1 << (t + 1)) - 30'd1;
      wbase = {2'b01, rnd[27:0]} & ~span;
      write_rule(0, make_cfg(1'b0, pmp_cfg_pkg::NAPOT, 1'b0, 1'b0, 1'b1),
                 {2'b00, wbase | (span >> 1)});
      expect_data({wbase, 2'b00}, 1'b0, 1'b1, exp_in);
      expect_data({wbase + span, 2'b11}, 1'b0, 1'b1, exp_in);
      for (int k = 0; k < 3; k++)
      begin
         rnd = $random(seed);
         expect_data({wbase + (rnd[29:0] & span), rnd[31:30]}, 1'b0, 1'b1, exp_in);
      end
      expect_data({wbase - 30'd1, 2'b00}, 1'b0, 1'b1, 1'b0);
      expect_data({wbase + span + 30'd1, 2'b00}, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic test_napot();
      clear_rules();
      priv_i = pmp_bus_pkg::U;
      napot_size(0, 1'b1);
      napot_size(3, 1'b1);
      napot_size(15, 1'b1);
      // one past the ceiling
      napot_size(16, 1'b0);
      write_rule(0, make_cfg(1'b0, pmp_cfg_pkg::NAPOT, 1'b0, 1'b0, 1'b1), 32'h3fff_ffff);
      expect_data(32'h0000_0000, 1'b0, 1'b1, 1'b0);
      expect_data(32'hffff_fffc, 1'b0, 1'b1, 1'b0);
      end_test("napot");
   endtask

   task automatic test_tor();
      logic [31:0] rnd;
      clear_rules();
      priv_i = pmp_bus_pkg::U;
      rnd    = $random(seed);
      // words 0x400 up to 0x800, bytes 0x1000 up to 0x2000
      write_rule(0, make_cfg(1'b0, pmp_cfg_pkg::OFF, 1'b0, 1'b0, 1'b0), 32'h0000_0400);
      write_rule(1, make_cfg(1'b0, pmp_cfg_pkg::TOR, 1'b1, 1'b0, 1'b0), 32'h0000_0800);
      expect_fetch(32'h0000_0ffc, 1'b1, 1'b0);
      expect_fetch(32'h0000_1000, 1'b1, 1'b1);
      expect_fetch({18'h0, 2'b01, rnd[9:0], 2'b00}, 1'b1, 1'b1);
      expect_fetch(32'h0000_1ffc, 1'b1, 1'b1);
      expect_fetch(32'h0000_2000, 1'b1, 1'b0);
      expect_data(32'h0000_1000, 1'b0, 1'b1, 1'b0);
      end_test("tor");
   endtask

   task automatic test_backpressure();
      clear_rules();
      priv_i = pmp_bus_pkg::U;
      write_rule(0, make_cfg(1'b0, pmp_cfg_pkg::NA4, 1'b0, 1'b1, 1'b1), 32'h0000_0100);
      repeat (4)
      begin
         expect_data(32'h0000_0400, 1'b1, 1'b0, 1'b1);
      end
      expect_data(32'h0000_0400, 1'b1, 1'b1, 1'b1);
      end_test("backpressure");
   endtask

   task automatic test_lock();
      clear_rules();
      priv_i = pmp_bus_pkg::U;
      write_rule(2, make_cfg(1'b1, pmp_cfg_pkg::NA4, 1'b0, 1'b0, 1'b1), 32'h0000_0300);
      write_rule(2, make_cfg(1'b0, pmp_cfg_pkg::NA4, 1'b0, 1'b0, 1'b1), 32'h0000_0340);
      expect_data(32'h0000_0c00, 1'b0, 1'b1, 1'b1);
      expect_data(32'h0000_0d00, 1'b0, 1'b1, 1'b0);
      write_rule(2, make_cfg(1'b0, pmp_cfg_pkg::OFF, 1'b0, 1'b0, 1'b0), 32'h0000_0000);
      expect_data(32'h0000_0c00, 1'b0, 1'b1, 1'b1);
      end_test("lock");
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial
   begin
      arst_n_i     = 1'b0;
      cfg_we_i     = 1'b0;
      cfg_idx_i    = '0;
      cfg_data_i   = '0;
      addr_data_i  = '0;
      priv_i       = pmp_bus_pkg::U;
      data_req_i   = 1'b0;
      data_addr_i  = '0;
      data_we_i    = 1'b0;
      data_gnt_i   = 1'b0;
      instr_req_i  = 1'b0;
      instr_addr_i = '0;
      instr_gnt_i  = 1'b0;
      repeat (8) @(posedge clk_i);
      #10;
      arst_n_i = 1'b1;

      test_reset_state();
      test_na4();
      test_napot();
      test_tor();
      test_backpressure();
      // entry 2 stays locked from here on
      test_lock();

      $display("%0d tests run, %0d failed, %0d check errors",
               test_cnt, failed_tests, err_cnt);
      if (err_cnt == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/pmp_cfg_pkg.sv
src/pmp_bus_pkg.sv
src/pmp_cfg_regs.sv
src/pmp_region_decode.sv
src/pmp_port_check.sv
src/pmp_top.sv
tb/pmp_tb.sv

//--- Makefile
# Verilator build and run for the PMP checker

VERILATOR ?= verilator
TOP       ?= pmp_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= STATUS: PASS

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)
